// ==== src/ddr2_ctrl_pkg.sv ====
/*
 * Shared types of the DDR2 control block
 * Control register indices and bit positions
 * Temperature reset code and maintenance FSM states
 */
package ddr2_ctrl_pkg;

   // Control bus widths
   typedef logic [3:0]  ctrl_addr_t;
   typedef logic [15:0] ctrl_data_t;

   // Temperature code as taken by the controller
   typedef logic [11:0] device_temp_t;

   // Register map
   localparam ctrl_addr_t REG_STATUS = 4'd0;
   localparam ctrl_addr_t REG_TEMP   = 4'd1;
   localparam ctrl_addr_t REG_MAINT  = 4'd2;

   // Roughly 25 degrees C
   localparam device_temp_t TEMP_RESET = 12'h977;

   // Status register bits
   localparam int STAT_CALIB_BIT = 0;
   localparam int STAT_RDY_BIT   = 1;

   // Maintenance request bits
   localparam int MAINT_REF_BIT = 0;
   localparam int MAINT_ZQ_BIT  = 1;

   typedef enum logic [1:0]
   {
      MS_CALIB   = 2'd0,
      MS_IDLE    = 2'd1,
      MS_REFRESH = 2'd2,
      MS_ZQ      = 2'd3
   } maint_state_t;

endpackage

// ==== src/clk_rst_gen.sv ====
/*
 * Bus clock forwarding and reset synchronizer
 * Reset asserts asynchronously and releases after two clock edges
 */
module clk_rst_gen
(
   input  logic sys_clk_i,
   input  logic async_rst_i,
   output logic wb_clk_o,
   output logic wb_rst_o
);

   logic [1:0] rst_sync;

   // Controller domain runs straight off the system clock
   assign wb_clk_o = sys_clk_i;

   // Two-stage synchronizer, ones shift out after release
   always_ff @(posedge sys_clk_i or posedge async_rst_i)
   begin
      if (async_rst_i)
      begin
         rst_sync <= 2'b11;
      end
      else
      begin
         rst_sync <= {rst_sync[0], 1'b0};
      end
   end

   assign wb_rst_o = rst_sync[1];

endmodule

// ==== src/ctrl_regs.sv ====
/*
 * Control Wishbone register block
 * Address decode, temperature and maintenance registers
 * Registered read-back, single-cycle acknowledge
 * Edge detectors for refresh and ZQ request pulses
 */
module ctrl_regs import ddr2_ctrl_pkg::*;
(
   input  logic         wb_clk_o,
   input  logic         async_rst_i,
   input  logic         wb_rst_o,

   input  ctrl_addr_t   wbc_adr_i,
   input  ctrl_data_t   wbc_dat_i,
   input  logic         wbc_we_i,
   input  logic         wbc_cyc_i,
   input  logic         wbc_stb_i,
   output ctrl_data_t   wbc_dat_o,
   output logic         wbc_ack_o,

   input  logic         init_calib_complete_i,
   input  logic         app_rdy_i,

   output device_temp_t device_temp_o,
   output logic         app_ref_req_o,
   output logic         app_zq_req_o
);

   localparam int NUM_REGS = 2 ** $bits(ctrl_addr_t);

   logic [NUM_REGS-1:0] sel;
   logic                bus_valid;
   logic                bus_access;
   logic                bus_write;
   logic                wr_maint;
   ctrl_data_t          rd_data;
   device_temp_t        temp_q;
   logic [1:0]          req_lvl;
   logic [1:0]          req_d1;
   logic [1:0]          req_d2;
   logic [1:0]          req_pulse;

   // One-hot address decode
   always_comb
   begin
      sel = '0;
      sel[wbc_adr_i] = 1'b1;
   end

   assign bus_valid  = wbc_cyc_i & wbc_stb_i;
   // First cycle of a valid access only, the ack cycle is not a new access
   assign bus_access = bus_valid & ~wbc_ack_o;
   assign bus_write  = bus_access & wbc_we_i;
   assign wr_maint   = bus_write & sel[REG_MAINT];

   // Device temperature register
   always_ff @(posedge wb_clk_o or posedge async_rst_i)
   begin
      if (async_rst_i)
      begin
         temp_q <= TEMP_RESET;
      end
      else if (wb_rst_o)
      begin
         temp_q <= TEMP_RESET;
      end
      else if (bus_write && sel[REG_TEMP])
      begin
         temp_q <= wbc_dat_i[$bits(device_temp_t)-1:0];
      end
   end

   assign device_temp_o = temp_q;

   // Request levels, then two history stages for edge detection
   always_ff @(posedge wb_clk_o or posedge async_rst_i)
   begin
      if (async_rst_i)
      begin
         req_lvl <= '0;
         req_d1  <= '0;
         req_d2  <= '0;
      end
      else if (wb_rst_o)
      begin
         req_lvl <= '0;
         req_d1  <= '0;
         req_d2  <= '0;
      end
      else
      begin
         req_lvl[MAINT_REF_BIT] <= wr_maint & wbc_dat_i[MAINT_REF_BIT];
         req_lvl[MAINT_ZQ_BIT]  <= wr_maint & wbc_dat_i[MAINT_ZQ_BIT];
         req_d1 <= req_lvl;
         req_d2 <= req_d1;
      end
   end

   // Rising edge of each level gives one pulse
   assign req_pulse     = req_d1 & ~req_d2;
   assign app_ref_req_o = req_pulse[MAINT_REF_BIT];
   assign app_zq_req_o  = req_pulse[MAINT_ZQ_BIT];

   // Read-back mux, unmapped slots read as zero
   always_comb
   begin
      rd_data = '0;
      if (sel[REG_STATUS])
      begin
         rd_data[STAT_CALIB_BIT] = init_calib_complete_i;
         rd_data[STAT_RDY_BIT]   = app_rdy_i;
      end
      else if (sel[REG_TEMP])
      begin
         rd_data = ctrl_data_t'(temp_q);
      end
   end

   // Acknowledge, never two cycles in a row
   always_ff @(posedge wb_clk_o or posedge async_rst_i)
   begin
      if (async_rst_i)
      begin
         wbc_ack_o <= 1'b0;
      end
      else if (wb_rst_o)
      begin
         wbc_ack_o <= 1'b0;
      end
      else
      begin
         wbc_ack_o <= bus_access;
      end
   end

   // Read data captured with the acknowledge
   always_ff @(posedge wb_clk_o)
   begin
      if (bus_access)
      begin
         wbc_dat_o <= rd_data;
      end
   end

endmodule

// ==== src/ui_maint_model.sv ====
/*
 * Behavioral model of the controller user interface
 * Calibration after reset, refresh and ZQ maintenance
 * Pending requests, app_rdy and acknowledge pulses
 */
module ui_maint_model import ddr2_ctrl_pkg::*;
#(
   parameter int CALIB_CYCLES = 64,
   parameter int MAINT_CYCLES = 8
)
(
   input  logic         wb_clk_o,
   input  logic         async_rst_i,
   input  logic         wb_rst_o,

   input  logic         app_ref_req_i,
   input  logic         app_zq_req_i,
   // Taken like the real controller does, the model ignores it
   input  device_temp_t device_temp_i,

   output logic         init_calib_complete_o,
   output logic         app_rdy_o,
   output logic         app_ref_ack_o,
   output logic         app_zq_ack_o
);

   localparam int CNT_MAX = (CALIB_CYCLES > MAINT_CYCLES) ? CALIB_CYCLES : MAINT_CYCLES;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   maint_state_t     state;
   logic [CNT_W-1:0] cnt;
   logic             ref_pend;
   logic             zq_pend;
   logic             calib_last;
   logic             maint_last;
   logic             start_ref;
   logic             start_zq;

   assign calib_last = (cnt == CNT_W'(CALIB_CYCLES - 1));
   assign maint_last = (cnt == CNT_W'(MAINT_CYCLES - 1));

   // Refresh wins when both are pending
   assign start_ref = (state == MS_IDLE) && ref_pend;
   assign start_zq  = (state == MS_IDLE) && !ref_pend && zq_pend;

   // Pending flags, a new request beats the clear
   always_ff @(posedge wb_clk_o or posedge async_rst_i)
   begin
      if (async_rst_i)
      begin
         ref_pend <= 1'b0;
         zq_pend  <= 1'b0;
      end
      else if (wb_rst_o)
      begin
         ref_pend <= 1'b0;
         zq_pend  <= 1'b0;
      end
      else
      begin
         ref_pend <= (ref_pend & ~start_ref) | app_ref_req_i;
         zq_pend  <= (zq_pend & ~start_zq) | app_zq_req_i;
      end
   end

   // FSM with one counter for calibration and maintenance
   always_ff @(posedge wb_clk_o or posedge async_rst_i)
   begin
      if (async_rst_i)
      begin
         state         <= MS_CALIB;
         cnt           <= '0;
         app_ref_ack_o <= 1'b0;
         app_zq_ack_o  <= 1'b0;
      end
      else if (wb_rst_o)
      begin
         state         <= MS_CALIB;
         cnt           <= '0;
         app_ref_ack_o <= 1'b0;
         app_zq_ack_o  <= 1'b0;
      end
      else
      begin
         app_ref_ack_o <= 1'b0;
         app_zq_ack_o  <= 1'b0;
         unique case (state)
            MS_CALIB:
            begin
               if (calib_last)
                  state <= MS_IDLE;
               else
                  cnt <= cnt + 1'b1;
            end
            MS_IDLE:
            begin
               // Counter restarts for the next operation
               cnt <= '0;
               if (start_ref)
                  state <= MS_REFRESH;
               else if (start_zq)
                  state <= MS_ZQ;
            end
            MS_REFRESH:
            begin
               if (maint_last)
               begin
                  state         <= MS_IDLE;
                  app_ref_ack_o <= 1'b1;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            MS_ZQ:
            begin
               if (maint_last)
               begin
                  state        <= MS_IDLE;
                  app_zq_ack_o <= 1'b1;
               end
               else
                  cnt <= cnt + 1'b1;
            end
         endcase
      end
   end

   assign init_calib_complete_o = (state != MS_CALIB);
   assign app_rdy_o             = (state == MS_IDLE);

endmodule

// ==== src/ddr2_ctrl_top.sv ====
/*
 * Top level of the DDR2 controller control side
 * Clock and reset, control registers, user interface model
 */
module ddr2_ctrl_top import ddr2_ctrl_pkg::*;
#(
   parameter int CALIB_CYCLES = 64,
   parameter int MAINT_CYCLES = 8
)
(
   input  logic       sys_clk_i,
   input  logic       async_rst_i,

   // Control bus
   input  ctrl_addr_t wbc_adr_i,
   input  ctrl_data_t wbc_dat_i,
   input  logic       wbc_we_i,
   input  logic       wbc_cyc_i,
   input  logic       wbc_stb_i,
   output ctrl_data_t wbc_dat_o,
   output logic       wbc_ack_o,

   output logic       wb_clk_o,
   output logic       wb_rst_o,

   // Controller status
   output logic       init_calib_complete_o,
   output logic       app_rdy_o,
   output logic       app_ref_ack_o,
   output logic       app_zq_ack_o
);

   logic         app_ref_req;
   logic         app_zq_req;
   device_temp_t device_temp;

   clk_rst_gen u_clk_rst_gen
   (
      .sys_clk_i   (sys_clk_i),
      .async_rst_i (async_rst_i),
      .wb_clk_o    (wb_clk_o),
      .wb_rst_o    (wb_rst_o)
   );

   ctrl_regs u_ctrl_regs
   (
      .wb_clk_o              (wb_clk_o),
      .async_rst_i           (async_rst_i),
      .wb_rst_o              (wb_rst_o),
      .wbc_adr_i             (wbc_adr_i),
      .wbc_dat_i             (wbc_dat_i),
      .wbc_we_i              (wbc_we_i),
      .wbc_cyc_i             (wbc_cyc_i),
      .wbc_stb_i             (wbc_stb_i),
      .wbc_dat_o             (wbc_dat_o),
      .wbc_ack_o             (wbc_ack_o),
      .init_calib_complete_i (init_calib_complete_o),
      .app_rdy_i             (app_rdy_o),
      .device_temp_o         (device_temp),
      .app_ref_req_o         (app_ref_req),
      .app_zq_req_o          (app_zq_req)
   );

   ui_maint_model
   #(
      .CALIB_CYCLES (CALIB_CYCLES),
      .MAINT_CYCLES (MAINT_CYCLES)
   )
   u_ui_maint_model
   (
      .wb_clk_o              (wb_clk_o),
      .async_rst_i           (async_rst_i),
      .wb_rst_o              (wb_rst_o),
      .app_ref_req_i         (app_ref_req),
      .app_zq_req_i          (app_zq_req),
      .device_temp_i         (device_temp),
      .init_calib_complete_o (init_calib_complete_o),
      .app_rdy_o             (app_rdy_o),
      .app_ref_ack_o         (app_ref_ack_o),
      .app_zq_ack_o          (app_zq_ack_o)
   );

endmodule

// ==== verif/ddr2_ctrl_properties.sv ====
/*
 * Concurrent checks on the control bus acknowledge
 * and on the maintenance outputs, bound to the top level
 */
module ddr2_ctrl_properties
(
   input logic wb_clk_i,
   input logic wb_rst_i,
   input logic wbc_ack_i,
   input logic init_calib_complete_i,
   input logic app_rdy_i,
   input logic app_ref_ack_i,
   input logic app_zq_ack_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;

   // Bus acknowledge is a single-cycle pulse
   ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbc_ack_i |=> !wbc_ack_i)
      else
      begin
         fail_cnt++;
         $error("wbc_ack_o stayed high for two cycles");
      end

   acks_exclusive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(app_ref_ack_i && app_zq_ack_i))
      else
      begin
         fail_cnt++;
         $error("refresh and ZQ acknowledges high together");
      end

   // Not ready before calibration is done
   rdy_after_calib: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !init_calib_complete_i |-> !app_rdy_i)
      else
      begin
         fail_cnt++;
         $error("app_rdy_o high before calibration completed");
      end

   ack_when_rdy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (app_ref_ack_i || app_zq_ack_i) |-> app_rdy_i)
      else
      begin
         fail_cnt++;
         $error("maintenance acknowledge while app_rdy_o is low");
      end

endmodule

bind ddr2_ctrl_top ddr2_ctrl_properties u_ddr2_ctrl_properties
(
   .wb_clk_i              (wb_clk_o),
   .wb_rst_i              (wb_rst_o),
   .wbc_ack_i             (wbc_ack_o),
   .init_calib_complete_i (init_calib_complete_o),
   .app_rdy_i             (app_rdy_o),
   .app_ref_ack_i         (app_ref_ack_o),
   .app_zq_ack_i          (app_zq_ack_o)
);

// ==== verif/tb_ddr2_ctrl.sv ====
/*
 * Testbench for the DDR2 control block
 * Random register traffic, maintenance requests, reference model
 */
module tb_ddr2_ctrl
   import ddr2_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CALIB_CYCLES  = 64;
   localparam int MAINT_CYCLES  = 8;
   localparam int ACK_TIMEOUT   = 16;
   localparam int CALIB_TIMEOUT = 4 * CALIB_CYCLES;
   localparam int MAINT_TIMEOUT = 16 * MAINT_CYCLES;
   localparam ctrl_data_t REF_MASK = ctrl_data_t'(1 << MAINT_REF_BIT);
   localparam ctrl_data_t ZQ_MASK  = ctrl_data_t'(1 << MAINT_ZQ_BIT);

   logic       sys_clk_i   = 1'b0;
   logic       async_rst_i = 1'b1;
   ctrl_addr_t wbc_adr_i   = '0;
   ctrl_data_t wbc_dat_i   = '0;
   logic       wbc_we_i    = 1'b0;
   logic       wbc_cyc_i   = 1'b0;
   logic       wbc_stb_i   = 1'b0;
   ctrl_data_t wbc_dat_o;
   logic       wbc_ack_o, wb_clk_o, wb_rst_o;
   logic       init_calib_complete_o, app_rdy_o, app_ref_ack_o, app_zq_ack_o;

   integer       seed = 32'h2381;
   int           errors = 0;
   int           checks = 0;
   // Model of pending maintenance and observed acknowledges
   int           exp_ref = 0;
   int           exp_zq = 0;
   int           ref_cnt = 0;
   int           zq_cnt = 0;
   int           zq_after_ref = 0;
   int           rdy_low_cnt = 0;
   device_temp_t temp_model;

   always #10 sys_clk_i = ~sys_clk_i;

   ddr2_ctrl_top
   #(
      .CALIB_CYCLES (CALIB_CYCLES),
      .MAINT_CYCLES (MAINT_CYCLES)
   )
   u_ddr2_ctrl_top
   (
      .sys_clk_i (sys_clk_i), .async_rst_i (async_rst_i),
      .wbc_adr_i (wbc_adr_i), .wbc_dat_i (wbc_dat_i), .wbc_we_i (wbc_we_i),
      .wbc_cyc_i (wbc_cyc_i), .wbc_stb_i (wbc_stb_i),
      .wbc_dat_o (wbc_dat_o), .wbc_ack_o (wbc_ack_o),
      .wb_clk_o (wb_clk_o), .wb_rst_o (wb_rst_o),
      .init_calib_complete_o (init_calib_complete_o), .app_rdy_o (app_rdy_o),
      .app_ref_ack_o (app_ref_ack_o), .app_zq_ack_o (app_zq_ack_o)
   );

   // Acknowledge monitor, sampled mid-cycle
   always @(negedge sys_clk_i)
   begin
      if (app_ref_ack_o)
         ref_cnt <= ref_cnt + 1;
      if (app_zq_ack_o)
      begin
         zq_cnt       <= zq_cnt + 1;
         zq_after_ref <= ref_cnt;
      end
      if (!app_rdy_o)
         rdy_low_cnt <= rdy_low_cnt + 1;
   end

   task automatic check(input string name, input ctrl_data_t exp_val, input ctrl_data_t act_val);
      checks++;
      if (exp_val !== act_val)
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
      end
   endtask

   // One classic cycle, held until the acknowledge
   task automatic bus_xfer(input logic we, input ctrl_addr_t adr, input ctrl_data_t dat,
                           output ctrl_data_t rdat);
      int n;
      n    = 0;
      rdat = '0;
      @(posedge sys_clk_i);
      wbc_adr_i <= adr;
      wbc_dat_i <= dat;
      wbc_we_i  <= we;
      wbc_cyc_i <= 1'b1;
      wbc_stb_i <= 1'b1;
      @(negedge sys_clk_i);
      while (!wbc_ack_o && n < ACK_TIMEOUT)
      begin
         @(negedge sys_clk_i);
         n++;
      end
      if (wbc_ack_o)
         rdat = wbc_dat_o;
      else
      begin
         errors++;
         $display("Timeout: no acknowledge for the access to address %0d", adr);
      end
      @(posedge sys_clk_i);
      wbc_cyc_i <= 1'b0;
      wbc_stb_i <= 1'b0;
      wbc_we_i  <= 1'b0;
      @(negedge sys_clk_i);
      check("ack lasts one cycle", '0, ctrl_data_t'(wbc_ack_o));
   endtask

   // Maintenance write or writes, then wait for all acknowledges
   task automatic request_maint(input string name, input ctrl_data_t first,
                                input ctrl_data_t second);
      ctrl_data_t rd;
      int         n;
      int         low_start;
      n         = 0;
      low_start = rdy_low_cnt;
      bus_xfer(1'b1, REG_MAINT, first, rd);
      if (second != '0)
         bus_xfer(1'b1, REG_MAINT, second, rd);
      exp_ref += int'(first[MAINT_REF_BIT]) + int'(second[MAINT_REF_BIT]);
      exp_zq  += int'(first[MAINT_ZQ_BIT]) + int'(second[MAINT_ZQ_BIT]);
      while ((ref_cnt < exp_ref || zq_cnt < exp_zq || !app_rdy_o) && n < MAINT_TIMEOUT)
      begin
         @(negedge sys_clk_i);
         n++;
      end
      if (ref_cnt < exp_ref || zq_cnt < exp_zq || !app_rdy_o)
      begin
         errors++;
         $display("Timeout: %s did not finish its maintenance", name);
      end
      check({name, " refresh acks"}, ctrl_data_t'(exp_ref), ctrl_data_t'(ref_cnt));
      check({name, " zq acks"}, ctrl_data_t'(exp_zq), ctrl_data_t'(zq_cnt));
      check({name, " app_rdy dropped"}, 16'd1, ctrl_data_t'(rdy_low_cnt > low_start));
      if (first[MAINT_ZQ_BIT] || second[MAINT_ZQ_BIT])
         check({name, " refresh before zq"}, ctrl_data_t'(exp_ref), ctrl_data_t'(zq_after_ref));
   endtask

   initial
   begin
      ctrl_data_t rd;
      ctrl_data_t wr;
      ctrl_data_t stat_exp;
      ctrl_addr_t adr;
      int         n;
      repeat (7) @(posedge sys_clk_i);
      @(negedge sys_clk_i);
      check("wb_rst_o during reset", 16'd1, ctrl_data_t'(wb_rst_o));
      @(posedge sys_clk_i);
      async_rst_i <= 1'b0;
      n = 0;
      while ((async_rst_i || wb_rst_o) && n < ACK_TIMEOUT)
      begin
         @(negedge sys_clk_i);
         n++;
      end
      if (wb_rst_o)
      begin
         errors++;
         $display("Timeout: wb_rst_o never released");
      end
      // One sample before the first edge out of reset, then two edges
      check("wb_rst_o release", 16'd3, ctrl_data_t'(n));
      check("calibration low after reset", '0, ctrl_data_t'(init_calib_complete_o));
      check("app_rdy low after reset", '0, ctrl_data_t'(app_rdy_o));
      bus_xfer(1'b0, REG_STATUS, '0, rd);
      check("status before calibration", '0, rd);

      // Bus clock follows the system clock, sampled away from its edges
      for (int i = 0; i < 4; i++)
      begin
         @(posedge sys_clk_i);
         #5;
         check("wb_clk_o high", 16'd1, ctrl_data_t'(wb_clk_o));
         #10;
         check("wb_clk_o low", '0, ctrl_data_t'(wb_clk_o));
      end

      temp_model = TEMP_RESET;
      bus_xfer(1'b0, REG_TEMP, '0, rd);
      check("reset temperature", ctrl_data_t'(temp_model), rd);

      n = 0;
      while (!init_calib_complete_o && n < CALIB_TIMEOUT)
      begin
         @(negedge sys_clk_i);
         n++;
      end
      if (!init_calib_complete_o)
      begin
         errors++;
         $display("Timeout: calibration never completed");
      end
      stat_exp = '0;
      stat_exp[STAT_CALIB_BIT] = 1'b1;
      stat_exp[STAT_RDY_BIT]   = 1'b1;
      bus_xfer(1'b0, REG_STATUS, '0, rd);
      check("status after calibration", stat_exp, rd);

      // Temperature keeps only the low 12 bits
      for (int i = 0; i < 16; i++)
      begin
         wr = ctrl_data_t'($random(seed));
         bus_xfer(1'b1, REG_TEMP, wr, rd);
         temp_model = device_temp_t'(wr);
         bus_xfer(1'b0, REG_TEMP, '0, rd);
         check("temperature write", ctrl_data_t'(temp_model), rd);
      end

      // Unmapped slots
      for (int i = 0; i < 16; i++)
      begin
         adr = ctrl_addr_t'(3 + {$random(seed)} % 13);
         wr  = ctrl_data_t'($random(seed));
         bus_xfer(1'b1, adr, wr, rd);
         bus_xfer(1'b0, adr, '0, rd);
         check("unmapped read", '0, rd);
      end
      bus_xfer(1'b0, REG_MAINT, '0, rd);
      check("maintenance read", '0, rd);
      bus_xfer(1'b0, REG_TEMP, '0, rd);
      check("temperature after unmapped writes", ctrl_data_t'(temp_model), rd);
      check("no refresh from unmapped writes", ctrl_data_t'(exp_ref), ctrl_data_t'(ref_cnt));
      check("no zq from unmapped writes", ctrl_data_t'(exp_zq), ctrl_data_t'(zq_cnt));

      request_maint("refresh only", REF_MASK, '0);
      request_maint("zq only", ZQ_MASK, '0);
      request_maint("refresh and zq", REF_MASK | ZQ_MASK, '0);
      request_maint("back to back", REF_MASK, ZQ_MASK);

      errors += u_ddr2_ctrl_top.u_ddr2_ctrl_properties.fail_cnt;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== ddr2_ctrl.f ====
src/ddr2_ctrl_pkg.sv
src/clk_rst_gen.sv
src/ctrl_regs.sv
src/ui_maint_model.sv
src/ddr2_ctrl_top.sv
verif/ddr2_ctrl_properties.sv
verif/tb_ddr2_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run, passing only when the output holds the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ddr2_ctrl.f --top-module tb_ddr2_ctrl -o sim_tb \
   || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "TEST PASSED" && echo "Simulation passed" && exit 0 \
   || { echo "Simulation failed"; exit 1; }
